// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --Mdir obj_dir
TOP       := tb_train_processor
FILELIST  := vlog.f
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: hw/bp_lane_if.sv
// Backprop operands and results of one neuron, host side drives operands and lane side returns deltap
`timescale 1ns/10ps
`default_nettype none

interface bp_lane_if;

	logic signed [train_pkg::WIDTH-1:0] deltan;                 // Neuron delta of the succeeding layer
	logic signed [train_pkg::WIDTH-1:0] sp        [train_pkg::FI]; // Sigmoid derivative per fan-in
	logic signed [train_pkg::WIDTH-1:0] w         [train_pkg::FI]; // Junction weights
	logic signed [train_pkg::WIDTH-1:0] partial_d [train_pkg::FI]; // Running delta sums
	logic signed [train_pkg::WIDTH-1:0] deltap    [train_pkg::FI]; // Updated delta sums

	modport lane (
		input  deltan, sp, w, partial_d,
		output deltap
	);

	modport host (
		output deltan, sp, w, partial_d,
		input  deltap
	);

endinterface

`default_nettype wire

// File: hw/delta_backprop_lane.sv
// Combinational backprop for one neuron, folds its delta into the FI partial delta sums of the layer before
`timescale 1ns/10ps
`default_nettype none

module delta_backprop_lane (
	bp_lane_if.lane lane_if
);

	// Intermediate products, one per fan-in weight
	logic signed [train_pkg::WIDTH-1:0] delta_sp [train_pkg::FI]; // deltan * sp
	logic signed [train_pkg::WIDTH-1:0] delta_w  [train_pkg::FI]; // deltan * sp * w

	// w.d.f' is split per weight, so each weight adds its own share
	// to the partial sum of the neuron it comes from
	for (genvar j = 0; j < train_pkg::FI; j++)
	begin : gen_fanin
		// Scale by the sigmoid derivative first
		assign delta_sp[j] = train_pkg::fxp_mul(lane_if.deltan, lane_if.sp[j]);

		// Then by the connecting weight, both multiplies clamp
		assign delta_w[j] = train_pkg::fxp_mul(delta_sp[j], lane_if.w[j]);

		// Accumulate, plain wrapping add at WIDTH
		assign lane_if.deltap[j] = lane_if.partial_d[j] + delta_w[j];
	end

endmodule

`default_nettype wire

// File: hw/learning_rate_reg.sv
// Learning-rate shift register, written by the host and read by every update lane
`timescale 1ns/10ps
`default_nettype none

module learning_rate_reg (
	input  wire logic                        clk,
	input  wire logic                        rst_n_i,
	input  wire logic                        eta_we_i,    // Load strobe
	input  wire logic [train_pkg::ETA_W-1:0] eta_shift_i, // New shift, eta = 2^-shift
	output      logic [train_pkg::ETA_W-1:0] eta_shift_o
);

	logic [train_pkg::ETA_W-1:0] eta_shift_q;

	// Zero after reset keeps the lanes from updating anything
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			eta_shift_q <= '0;
		end
		else if (eta_we_i)
		begin
			eta_shift_q <= eta_shift_i; // Seen by operands from the next edge on
		end
	end

	assign eta_shift_o = eta_shift_q;

endmodule

`default_nettype wire

// File: hw/param_update_lane.sv
// Combinational bias and weight update for one neuron with the power-of-two learning rate and overflow guard
`timescale 1ns/10ps
`default_nettype none

module param_update_lane (
	update_lane_if.lane                      lane_if,
	input  wire logic [train_pkg::ETA_W-1:0] eta_shift_i // Zero disables updates
);

	logic signed [train_pkg::WIDTH-1:0] delta_neg;               // -delta, wraps
	logic signed [train_pkg::WIDTH-1:0] delta_scaled;            // -delta * eta
	logic signed [train_pkg::WIDTH-1:0] bias_step;               // Step applied to b
	logic signed [train_pkg::WIDTH-1:0] w_step [train_pkg::FI];  // Step applied to each w
	logic                               upd_en;                  // Training has started

	assign upd_en = (eta_shift_i != '0);

	// Negate before shifting, keeps one more bit of precision
	// than shifting and then negating
	assign delta_neg = -lane_if.delta;

	// eta is 2^-shift, so the multiply is an arithmetic shift
	assign delta_scaled = delta_neg >>> eta_shift_i;

	// No step at all before the first learning rate is written
	assign bias_step = upd_en ? delta_scaled : '0;

	// Bias moves by the step unless it would wrap
	assign lane_if.b_up = train_pkg::guarded_add(lane_if.b, bias_step);

	// Weight gradient is bias step times the feeding activation
	for (genvar j = 0; j < train_pkg::FI; j++)
	begin : gen_weight
		// Zero bias step gives zero weight step, so w is held too
		assign w_step[j] = train_pkg::fxp_mul(bias_step, lane_if.a[j]);

		// Sign-based guard, old=28 step=6 keeps 28 and old=1 step=-2 gives -1
		assign lane_if.w_up[j] = train_pkg::guarded_add(lane_if.w[j], w_step[j]);
	end

endmodule

`default_nettype wire

// File: hw/train_pkg.sv
// Shared word geometry and fixed-point helpers, referenced by scoped name from every RTL file
`default_nettype none

package train_pkg;

	// Word geometry, two's complement Q5.10 plus sign
	localparam int WIDTH     = 16;
	localparam int FRAC_BITS = 10;                  // Fractional bits
	localparam int INT_BITS  = 5;                   // Integer bits, sign excluded
	localparam int FI        = 4;                   // Fan-in weights per neuron
	localparam int Z         = 8;                   // Weights per transfer
	localparam int NEURONS   = Z / FI;              // Neurons served per transfer
	localparam int ETA_W     = $clog2(FRAC_BITS + 1); // Learning-rate shift field

	// Full product width before rescaling
	localparam int PROD_W = 2 * WIDTH;

	// Saturation limits of one word
	localparam logic [WIDTH-1:0] WORD_MAX = {1'b0, {(WIDTH-1){1'b1}}};
	localparam logic [WIDTH-1:0] WORD_MIN = {1'b1, {(WIDTH-1){1'b0}}};

	// Fixed-point multiply, rescale by FRAC_BITS and clamp to one word
	function automatic logic signed [WIDTH-1:0] fxp_mul(
		input logic signed [WIDTH-1:0] op_a,
		input logic signed [WIDTH-1:0] op_b
	);
		logic signed [PROD_W-1:0] prod;
		logic signed [PROD_W-1:0] scaled;
		prod   = op_a * op_b;              // Operands sign extended to PROD_W
		scaled = prod >>> FRAC_BITS;       // Back to word scaling
		// Bits above the word must all copy the sign bit, else clamp
		if (!scaled[PROD_W-1] && (|scaled[PROD_W-2:WIDTH-1]))
			return WORD_MAX;
		else if (scaled[PROD_W-1] && !(&scaled[PROD_W-2:WIDTH-1]))
			return WORD_MIN;
		else
			return scaled[WIDTH-1:0];
	endfunction

	// Wrapping add that keeps the old value when the sum overflows
	function automatic logic signed [WIDTH-1:0] guarded_add(
		input logic signed [WIDTH-1:0] old_v,
		input logic signed [WIDTH-1:0] step_v
	);
		logic signed [WIDTH-1:0] sum;
		sum = old_v + step_v; // Wraps at WIDTH
		// Same-sign operands with a flipped result sign mean wrap-around
		if ((old_v[WIDTH-1] == step_v[WIDTH-1]) && (sum[WIDTH-1] != old_v[WIDTH-1]))
			return old_v;
		return sum;
	endfunction

endpackage

`default_nettype wire

// File: hw/train_processor_top.sv
// Training datapath top, takes packed operand vectors with valid_i and returns registered backprop and update results one cycle later
`timescale 1ns/10ps
`default_nettype none

module train_processor_top (
	input  wire logic                                            clk,
	input  wire logic                                            rst_n_i,
	input  wire logic                                            valid_i,     // Operand set strobe
	input  wire logic                                            eta_we_i,    // Learning-rate write
	input  wire logic [train_pkg::ETA_W-1:0]                     eta_shift_i,
	input  wire logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0]  deltan_i,    // One delta per neuron
	input  wire logic [train_pkg::WIDTH*train_pkg::Z-1:0]        sp_i,
	input  wire logic [train_pkg::WIDTH*train_pkg::Z-1:0]        w_i,
	input  wire logic [train_pkg::WIDTH*train_pkg::Z-1:0]        partial_d_i,
	input  wire logic [train_pkg::WIDTH*train_pkg::Z-1:0]        a_i,         // Activations
	input  wire logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0]  b_i,         // One bias per neuron
	output      logic                                            valid_o,
	output      logic [train_pkg::WIDTH*train_pkg::Z-1:0]        deltap_o,
	output      logic [train_pkg::WIDTH*train_pkg::Z-1:0]        w_up_o,
	output      logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0]  b_up_o
);

	logic [train_pkg::ETA_W-1:0] eta_shift; // Current learning-rate shift

	// Lane results before the output register
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       deltap_d;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       w_up_d;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] b_up_d;

	// Output register
	logic                                           valid_q;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       deltap_q;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       w_up_q;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] b_up_q;

	learning_rate_reg u_eta (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.eta_we_i    (eta_we_i),
		.eta_shift_i (eta_shift_i),
		.eta_shift_o (eta_shift)
	);

	// Neuron k owns words k*FI .. k*FI+FI-1 of every Z-wide vector
	for (genvar k = 0; k < train_pkg::NEURONS; k++)
	begin : gen_neuron
		bp_lane_if     bp_if ();
		update_lane_if up_if ();

		// Per-neuron words
		assign bp_if.deltan = deltan_i[train_pkg::WIDTH*k +: train_pkg::WIDTH];
		assign up_if.delta  = deltan_i[train_pkg::WIDTH*k +: train_pkg::WIDTH]; // Same delta feeds both
		assign up_if.b      = b_i[train_pkg::WIDTH*k +: train_pkg::WIDTH];
		assign b_up_d[train_pkg::WIDTH*k +: train_pkg::WIDTH] = up_if.b_up;

		// Per-weight words
		for (genvar j = 0; j < train_pkg::FI; j++)
		begin : gen_word
			localparam int IDX = k * train_pkg::FI + j; // Word index in the transfer

			assign bp_if.sp[j]        = sp_i[train_pkg::WIDTH*IDX +: train_pkg::WIDTH];
			assign bp_if.w[j]         = w_i[train_pkg::WIDTH*IDX +: train_pkg::WIDTH];
			assign bp_if.partial_d[j] = partial_d_i[train_pkg::WIDTH*IDX +: train_pkg::WIDTH];
			assign up_if.w[j]         = w_i[train_pkg::WIDTH*IDX +: train_pkg::WIDTH]; // Shared with backprop
			assign up_if.a[j]         = a_i[train_pkg::WIDTH*IDX +: train_pkg::WIDTH];

			// Repack results
			assign deltap_d[train_pkg::WIDTH*IDX +: train_pkg::WIDTH] = bp_if.deltap[j];
			assign w_up_d[train_pkg::WIDTH*IDX +: train_pkg::WIDTH]   = up_if.w_up[j];
		end

		delta_backprop_lane u_bp (
			.lane_if (bp_if.lane)
		);

		param_update_lane u_up (
			.lane_if     (up_if.lane),
			.eta_shift_i (eta_shift)
		);
	end

	// Single pipeline stage, results follow operands by one cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			valid_q  <= 1'b0;
			deltap_q <= '0;
			w_up_q   <= '0;
			b_up_q   <= '0;
		end
		else
		begin
			valid_q <= valid_i; // One-cycle strobe per accepted set
			if (valid_i)
			begin
				deltap_q <= deltap_d;
				w_up_q   <= w_up_d;
				b_up_q   <= b_up_d;
			end
			// Otherwise hold the last results
		end
	end

	assign valid_o  = valid_q;
	assign deltap_o = deltap_q;
	assign w_up_o   = w_up_q;
	assign b_up_o   = b_up_q;

endmodule

`default_nettype wire

// File: hw/update_lane_if.sv
// Parameter-update operands and results of one neuron, host side drives old values, lane side returns new ones
`timescale 1ns/10ps
`default_nettype none

interface update_lane_if;

	// Operands from the host
	logic signed [train_pkg::WIDTH-1:0] delta;              // Neuron delta
	logic signed [train_pkg::WIDTH-1:0] b;                  // Current bias
	logic signed [train_pkg::WIDTH-1:0] w    [train_pkg::FI]; // Current weights
	logic signed [train_pkg::WIDTH-1:0] a    [train_pkg::FI]; // Preceding-layer activations, non-negative

	// Results from the lane
	logic signed [train_pkg::WIDTH-1:0] b_up;                // Guarded new bias
	logic signed [train_pkg::WIDTH-1:0] w_up [train_pkg::FI]; // Guarded new weights

	modport lane (
		input  delta, b, w, a,
		output b_up, w_up
	);

	modport host (
		output delta, b, w, a,
		input  b_up, w_up
	);

endinterface

`default_nettype wire

// File: verification/tb_ref_model.svh
// Expected-value model of the training datapath, included inside the testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef logic signed [train_pkg::WIDTH-1:0] word_t; // One fixed-point word

// Saturating fixed-point product, worked out in wide integers
function automatic word_t sat_product(input word_t x, input word_t y);
	longint p;
	longint hi;
	longint lo;
	hi = (longint'(1) <<< (train_pkg::WIDTH - 1)) - 1;  // Most positive word
	lo = -(longint'(1) <<< (train_pkg::WIDTH - 1));     // Most negative word
	p  = longint'(x) * longint'(y);
	p  = p >>> train_pkg::FRAC_BITS;                   // Floor, like an arithmetic shift
	if (p > hi)
		p = hi;
	if (p < lo)
		p = lo;
	return p[train_pkg::WIDTH-1:0];
endfunction

// Partial delta plus the twice-scaled neuron delta, wraps at the word size
function automatic word_t backprop_word(
	input word_t pd,
	input word_t dn,
	input word_t sp,
	input word_t w
);
	int s;
	s = int'(pd) + int'(sat_product(sat_product(dn, sp), w));
	return s[train_pkg::WIDTH-1:0];
endfunction

// Negated delta times 2^-shift, nothing while the shift is zero
function automatic word_t bias_step_of(
	input word_t                         delta,
	input logic [train_pkg::ETA_W-1:0]   shift
);
	int    neg;
	word_t wrapped;
	if (shift == '0)
		return '0;
	neg     = -int'(delta);
	wrapped = neg[train_pkg::WIDTH-1:0]; // -(-1.0 * 32) wraps back to itself
	return wrapped >>> shift;
endfunction

// Old value stays when the exact sum leaves the word range
function automatic word_t keep_on_wrap(input word_t old_v, input word_t step_v);
	longint s;
	longint hi;
	longint lo;
	hi = (longint'(1) <<< (train_pkg::WIDTH - 1)) - 1;
	lo = -(longint'(1) <<< (train_pkg::WIDTH - 1));
	s  = longint'(old_v) + longint'(step_v);
	if (s > hi || s < lo)
		return old_v;
	return s[train_pkg::WIDTH-1:0];
endfunction

`endif

// File: verification/tb_train_processor.sv
// Testbench top, drives random and directed sets into the training datapath and checks the results
`timescale 1ns/10ps
`default_nettype none

module tb_train_processor;

	logic                                           clk;
	logic                                           rst_n_i;
	logic                                           valid_i;
	logic                                           eta_we_i;
	logic [train_pkg::ETA_W-1:0]                    eta_shift_i;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] deltan_i;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       sp_i;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       w_i;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       partial_d_i;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       a_i;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] b_i;
	logic                                           valid_o;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       deltap_o;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       w_up_o;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] b_up_o;

	// Operands of the next set as prepared before the drive edge
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] nx_deltan;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       nx_sp;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       nx_w;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       nx_pd;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       nx_a;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] nx_b;

	logic [train_pkg::ETA_W-1:0] model_shift;   // Shift the DUT applies to the next sampled set
	int                          cycle_cnt = 0;
	int                          value_errs = 0;
	int                          other_errs = 0;

	// Pending results with one entry per driven set
	string                                          exp_name_q [$];
	int                                             exp_due_q  [$]; // Cycle of the valid_o pulse
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       exp_dp_q   [$];
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       exp_wu_q   [$];
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] exp_bu_q   [$];

	// Results the output register keeps while valid_o is low
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       held_dp = '0;
	logic [train_pkg::WIDTH*train_pkg::Z-1:0]       held_wu = '0;
	logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] held_bu = '0;

	`include "tb_ref_model.svh"

	train_processor_top i_dut (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.valid_i     (valid_i),
		.eta_we_i    (eta_we_i),
		.eta_shift_i (eta_shift_i),
		.deltan_i    (deltan_i),
		.sp_i        (sp_i),
		.w_i         (w_i),
		.partial_d_i (partial_d_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.valid_o     (valid_o),
		.deltap_o    (deltap_o),
		.w_up_o      (w_up_o),
		.b_up_o      (b_up_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// Word in -2.0 .. +2.0 keeps most products out of saturation
	function automatic word_t around_zero(input logic [31:0] r);
		return {4'b0000, r[11:0]} - 16'd2048;
	endfunction

	task automatic make_ops(input bit full_range);
		logic [31:0] r;
		for (int i = 0; i < train_pkg::Z; i++)
		begin
			r = $urandom();
			nx_sp[train_pkg::WIDTH*i +: train_pkg::WIDTH] = full_range ? r[15:0] : around_zero(r);
			r = $urandom();
			nx_w[train_pkg::WIDTH*i +: train_pkg::WIDTH] = full_range ? r[15:0] : around_zero(r);
			r = $urandom();
			nx_pd[train_pkg::WIDTH*i +: train_pkg::WIDTH] = r[15:0];
			r = $urandom();
			// Activations never negative
			nx_a[train_pkg::WIDTH*i +: train_pkg::WIDTH] = full_range ? {1'b0, r[14:0]}
				: {4'b0000, r[11:0]};
		end
		for (int k = 0; k < train_pkg::NEURONS; k++)
		begin
			r = $urandom();
			nx_deltan[train_pkg::WIDTH*k +: train_pkg::WIDTH] = full_range ? r[15:0]
				: around_zero(r);
			r = $urandom();
			nx_b[train_pkg::WIDTH*k +: train_pkg::WIDTH] = r[15:0];
		end
	endtask

	// Reference result of the prepared set under the modelled shift
	task automatic push_expected(input string name, input int due);
		logic [train_pkg::WIDTH*train_pkg::Z-1:0]       dp;
		logic [train_pkg::WIDTH*train_pkg::Z-1:0]       wu;
		logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] bu;
		word_t                                          step;
		int                                             idx;
		for (int k = 0; k < train_pkg::NEURONS; k++)
		begin
			step = bias_step_of(nx_deltan[train_pkg::WIDTH*k +: train_pkg::WIDTH], model_shift);
			bu[train_pkg::WIDTH*k +: train_pkg::WIDTH] =
				keep_on_wrap(nx_b[train_pkg::WIDTH*k +: train_pkg::WIDTH], step);
			for (int j = 0; j < train_pkg::FI; j++)
			begin
				idx = k * train_pkg::FI + j;
				dp[train_pkg::WIDTH*idx +: train_pkg::WIDTH] = backprop_word(
					nx_pd[train_pkg::WIDTH*idx +: train_pkg::WIDTH],
					nx_deltan[train_pkg::WIDTH*k +: train_pkg::WIDTH],
					nx_sp[train_pkg::WIDTH*idx +: train_pkg::WIDTH],
					nx_w[train_pkg::WIDTH*idx +: train_pkg::WIDTH]);
				wu[train_pkg::WIDTH*idx +: train_pkg::WIDTH] = keep_on_wrap(
					nx_w[train_pkg::WIDTH*idx +: train_pkg::WIDTH],
					sat_product(step, nx_a[train_pkg::WIDTH*idx +: train_pkg::WIDTH]));
			end
		end
		exp_name_q.push_back(name);
		exp_due_q.push_back(due);
		exp_dp_q.push_back(dp);
		exp_wu_q.push_back(wu);
		exp_bu_q.push_back(bu);
	endtask

	// One operand set per call with an optional shift write in the same cycle
	task automatic send_set(input string name, input bit we,
		input logic [train_pkg::ETA_W-1:0] sh);
		@(posedge clk);
		valid_i     <= 1'b1;
		eta_we_i    <= we;
		eta_shift_i <= sh;
		deltan_i    <= nx_deltan;
		sp_i        <= nx_sp;
		w_i         <= nx_w;
		partial_d_i <= nx_pd;
		a_i         <= nx_a;
		b_i         <= nx_b;
		push_expected(name, cycle_cnt + 2); // Sampled at the next edge and visible the edge after
		if (we)
			model_shift = sh; // This set still sees the old shift
	endtask

	task automatic load_shift(input logic [train_pkg::ETA_W-1:0] sh);
		@(posedge clk);
		valid_i     <= 1'b0;
		eta_we_i    <= 1'b1;
		eta_shift_i <= sh;
		model_shift = sh;
	endtask

	task automatic go_idle(input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(posedge clk);
			valid_i     <= 1'b0;
			eta_we_i    <= 1'b0;
			// Changed operands with valid_i low must not reach the outputs
			deltan_i    <= ~deltan_i;
			sp_i        <= ~sp_i;
			w_i         <= ~w_i;
			partial_d_i <= ~partial_d_i;
			b_i         <= ~b_i;
		end
	endtask

	task automatic wait_drain(output bit drained);
		int waited;
		waited = 0;
		while (exp_due_q.size() != 0 && waited < 20)
		begin
			@(posedge clk);
			waited++;
		end
		drained = (exp_due_q.size() == 0);
		if (!drained)
		begin
			$display("Timeout: %0d results still missing after 20 cycles", exp_due_q.size());
			other_errs++;
		end
	endtask

	// Outputs settle after the rising edge and are read at the falling one
	always @(negedge clk)
	begin : compare_results
		string                                          nm;
		int                                             due;
		logic [train_pkg::WIDTH*train_pkg::Z-1:0]       e_dp;
		logic [train_pkg::WIDTH*train_pkg::Z-1:0]       e_wu;
		logic [train_pkg::WIDTH*train_pkg::NEURONS-1:0] e_bu;
		if (valid_o === 1'b1)
		begin
			if (exp_due_q.size() == 0)
			begin
				$display("valid_o pulsed at cycle %0d with no operand set pending", cycle_cnt);
				other_errs++;
			end
			else
			begin
				nm   = exp_name_q.pop_front();
				due  = exp_due_q.pop_front();
				e_dp = exp_dp_q.pop_front();
				e_wu = exp_wu_q.pop_front();
				e_bu = exp_bu_q.pop_front();
				held_dp = e_dp;
				held_wu = e_wu;
				held_bu = e_bu;
				if (due != cycle_cnt)
				begin
					$display("Fail %s: result cycle expected %0d actual %0d", nm, due, cycle_cnt);
					value_errs++;
				end
				for (int i = 0; i < train_pkg::Z; i++)
				begin
					if (deltap_o[train_pkg::WIDTH*i +: train_pkg::WIDTH]
						!== e_dp[train_pkg::WIDTH*i +: train_pkg::WIDTH])
					begin
						$display("Fail %s: deltap word %0d expected %h actual %h", nm, i,
							e_dp[train_pkg::WIDTH*i +: train_pkg::WIDTH],
							deltap_o[train_pkg::WIDTH*i +: train_pkg::WIDTH]);
						value_errs++;
					end
					if (w_up_o[train_pkg::WIDTH*i +: train_pkg::WIDTH]
						!== e_wu[train_pkg::WIDTH*i +: train_pkg::WIDTH])
					begin
						$display("Fail %s: w_up word %0d expected %h actual %h", nm, i,
							e_wu[train_pkg::WIDTH*i +: train_pkg::WIDTH],
							w_up_o[train_pkg::WIDTH*i +: train_pkg::WIDTH]);
						value_errs++;
					end
				end
				for (int k = 0; k < train_pkg::NEURONS; k++)
				begin
					if (b_up_o[train_pkg::WIDTH*k +: train_pkg::WIDTH]
						!== e_bu[train_pkg::WIDTH*k +: train_pkg::WIDTH])
					begin
						$display("Fail %s: b_up neuron %0d expected %h actual %h", nm, k,
							e_bu[train_pkg::WIDTH*k +: train_pkg::WIDTH],
							b_up_o[train_pkg::WIDTH*k +: train_pkg::WIDTH]);
						value_errs++;
					end
				end
			end
		end
		else
		begin
			if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt)
			begin
				$display("Set %s got no valid_o pulse at cycle %0d", exp_name_q[0], cycle_cnt);
				other_errs++;
				void'(exp_name_q.pop_front());
				void'(exp_due_q.pop_front());
				void'(exp_dp_q.pop_front());
				void'(exp_wu_q.pop_front());
				void'(exp_bu_q.pop_front());
			end
			// Without a result pulse the last set stays on the outputs
			if (rst_n_i === 1'b1 && (deltap_o !== held_dp || w_up_o !== held_wu
				|| b_up_o !== held_bu))
			begin
				$display("Fail hold: deltap/w_up/b_up expected %h %h %h actual %h %h %h",
					held_dp, held_wu, held_bu, deltap_o, w_up_o, b_up_o);
				value_errs++;
			end
		end
	end

	initial
	begin : main_seq
		logic [31:0]                 r;
		logic [train_pkg::ETA_W-1:0] sh;
		bit                          drained;
		void'($urandom(8));
		rst_n_i     = 1'b0;
		valid_i     = 1'b0;
		eta_we_i    = 1'b0;
		eta_shift_i = '0;
		deltan_i    = '0;
		sp_i        = '0;
		w_i         = '0;
		partial_d_i = '0;
		a_i         = '0;
		b_i         = '0;
		model_shift = '0;
		repeat (4) @(posedge clk);
		rst_n_i <= 1'b1;

		// Reset values first and then an idle stretch with no valid_o allowed
		@(negedge clk);
		if (valid_o !== 1'b0 || deltap_o !== '0 || w_up_o !== '0 || b_up_o !== '0)
		begin
			$display("Fail reset_values: expected 0 actual valid %b deltap %h w_up %h b_up %h",
				valid_o, deltap_o, w_up_o, b_up_o);
			value_errs++;
		end
		go_idle(5);

		// Shift still zero so parameters must come back unchanged
		for (int n = 0; n < 10; n++)
		begin
			make_ops(1'b1);
			send_set("no_update", 1'b0, '0);
		end

		// Backprop over small and full-range operands where full range often saturates
		for (int n = 0; n < 40; n++)
		begin
			make_ops((n % 2) == 1);
			send_set("backprop", 1'b0, '0);
		end
		nx_deltan = {2{16'h7FFF}};
		nx_sp     = {8{16'h7FFF}};
		nx_w      = {4{16'h8000, 16'h7FFF}};
		nx_pd     = {8{16'h7000}};
		send_set("backprop_sat", 1'b0, '0);
		go_idle(2);

		// Parameter update over the whole shift range
		for (int n = 0; n < 20; n++)
		begin
			r = $urandom_range(train_pkg::FRAC_BITS, 1);
			load_shift(r[train_pkg::ETA_W-1:0]);
			for (int m = 0; m < 3; m++)
			begin
				make_ops(m == 1);
				send_set("update", 1'b0, '0);
			end
		end
		go_idle(2);

		// Neuron 0 would wrap past +32 and is held, neuron 1 crosses zero
		load_shift(train_pkg::ETA_W'(1));
		make_ops(1'b0);
		nx_b[15:0]       = 16'h7F00;
		nx_deltan[15:0]  = 16'hF800; // -2.0
		nx_b[31:16]      = 16'h0010;
		nx_deltan[31:16] = 16'h0100; // +0.25
		send_set("overflow_guard", 1'b0, '0);
		go_idle(2);

		// Back-to-back stream with a shift write in the middle
		sh = '0;
		for (int n = 0; n < 50; n++)
		begin
			make_ops((n % 2) == 1);
			if (n == 25)
			begin
				r  = $urandom_range(train_pkg::FRAC_BITS, 1);
				sh = r[train_pkg::ETA_W-1:0];
			end
			send_set("stream", n == 25, sh);
		end
		go_idle(1);

		wait_drain(drained);
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (drained && value_errs == 0 && other_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verification
hw/train_pkg.sv
hw/bp_lane_if.sv
hw/update_lane_if.sv
hw/learning_rate_reg.sv
hw/delta_backprop_lane.sv
hw/param_update_lane.sv
hw/train_processor_top.sv
verification/tb_train_processor.sv
